//--- run_sim.sh
#!/usr/bin/env bash
# build and run the line player testbench with Verilator.
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing -Wno-fatal --top-module tb_line_player -f verilog.f \
	-o tb_line_player > "$log" 2>&1 \
	&& ./obj_dir/tb_line_player >> "$log" 2>&1 \
	|| { cat "$log"; echo "build or simulation did not complete"; exit 1; }
cat "$log"
grep -q "CHECKS FAILED" "$log" && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" "$log" || { echo "no pass message in $log"; exit 1; }
echo "simulation passed"

//--- sim/tb_line_player.sv
`timescale 1ns/1ps

module tb_line_player;

	localparam int CLK_PERIOD = 40;
	localparam int ROUNDS = 2;
	localparam int MAX_GEN = line_pkg::BUFF_LEN + 16; // largest generator store.
	// handshakes of one round over writes and plays of both modes.
	localparam int HS_ROUND = 4 * MAX_GEN + 4 + 4 * line_pkg::BUFF_LEN + 4;
	localparam int HS_FULL = 3 * line_pkg::DEPTH + 1;
	localparam int HS_CYCLES = 32; // ack delay, restart hold and refill.
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_NS =
		((ROUNDS * HS_ROUND + HS_FULL) * HS_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	logic clk;
	logic rst_gen_mode;
	logic host_req;
	line_pkg::line_t host_data;
	logic play;
	logic restart;
	logic out_ack;
	logic host_ack;
	logic out_req;
	line_pkg::play_line_t out_line;
	line_pkg::player_status_t status;

	logic [15:0] lfsr;
	line_pkg::line_t model_mem [line_pkg::DEPTH]; // lines written since the last stop.
	int model_count;
	int exp_index;
	int value_errors;
	int other_errors;

	line_player_top i_line_player_top (
		.clk(clk),
		.rst_gen_mode(rst_gen_mode),
		.host_req(host_req),
		.host_data(host_data),
		.play(play),
		.restart(restart),
		.out_ack(out_ack),
		.host_ack(host_ack),
		.out_req(out_req),
		.out_line(out_line),
		.status(status)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

	// ************************************************************
	// random numbers and checks
	// ************************************************************

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic line_pkg::player_status_t make_status(input logic w, input logic p,
			input logic e);
		line_pkg::player_status_t s;
		s.write_rdy = w;
		s.playing = p;
		s.error = e;
		return s;
	endfunction

	task automatic check_line(input string name, input line_pkg::play_line_t exp,
			input line_pkg::play_line_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected index %0d data %h, actual index %0d data %h",
				name, exp.index, exp.data, act.index, act.data);
			value_errors++;
		end
	endtask

	task automatic check_status(input string name, input line_pkg::player_status_t exp,
			input line_pkg::player_status_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected status %b, actual %b (write_rdy playing error)",
				name, exp, act);
			value_errors++;
		end
	endtask

	// ************************************************************
	// host and downstream sides
	// ************************************************************

	task automatic write_lines(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			rand_bits(line_pkg::LINE_WIDTH, r);
			host_data = r[line_pkg::LINE_WIDTH-1:0];
			host_req = 1'b1;
			@(negedge clk);
			while (!host_ack) begin
				@(negedge clk);
			end
			host_req = 1'b0;
			model_mem[model_count] = host_data;
			model_count++;
			@(negedge clk);
			while (host_ack) begin
				@(negedge clk);
			end
		end
	endtask

	task automatic do_restart(input string name);
		logic [31:0] r;
		rand_bits(2, r);
		restart = 1'b1;
		@(negedge clk);
		check_status(name, make_status(1'b0, 1'b0, 1'b0), status); // playing gone.
		repeat (int'(r)) @(negedge clk);
		restart = 1'b0;
		exp_index = 0; // the line held by the streamer was the last old one.
	endtask

	// accepts n lines; restart_at picks the handshake to restart in, -1 for none.
	task automatic play_lines(input string name, input int n, input int restart_at);
		logic [31:0] r;
		line_pkg::play_line_t exp_line;
		for (int h = 0; h < n; h++) begin
			while (!out_req) begin
				@(negedge clk);
			end
			check_status(name, make_status(1'b0, 1'b1, 1'b0), status); // lines available.
			exp_line.index = line_pkg::line_addr_t'(exp_index);
			exp_line.data = model_mem[exp_index];
			check_line(name, exp_line, out_line);
			exp_index = (exp_index + 1) % model_count;
			rand_bits(3, r);
			repeat (int'(r)) @(negedge clk); // slow ack.
			if (h == restart_at) begin
				do_restart(name);
			end
			out_ack = 1'b1;
			@(negedge clk);
			while (out_req) begin
				@(negedge clk);
			end
			out_ack = 1'b0;
		end
	endtask

	task automatic stop_play(input string name);
		play = 1'b0;
		repeat (2) @(negedge clk);
		check_status(name, make_status(1'b1, 1'b0, 1'b0), status);
		model_count = 0; // store emptied.
	endtask

	task automatic play_round(input string name, input int count);
		logic [31:0] r;
		write_lines(count);
		play = 1'b1;
		exp_index = 0;
		play_lines(name, 2 * count + 1, -1);
		rand_bits(5, r);
		play_lines({name, " restart"}, count + 3, int'(r) % count);
		stop_play({name, " stop"});
	endtask

	task automatic empty_store(input string name);
		play = 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			if (out_req) begin
				$display("%s: out_req went high while playing an empty store", name);
				other_errors++;
			end
		end
		check_status(name, make_status(1'b0, 1'b0, 1'b1), status);
		stop_play({name, " stop"});
	endtask

	task automatic full_store();
		logic [31:0] r;
		write_lines(line_pkg::DEPTH);
		check_status("full store", make_status(1'b0, 1'b0, 1'b0), status);
		rand_bits(line_pkg::LINE_WIDTH, r);
		host_data = r[line_pkg::LINE_WIDTH-1:0];
		host_req = 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			if (host_ack) begin
				$display("full store: host_ack answered a write to a full store");
				other_errors++;
			end
		end
		host_req = 1'b0;
		@(negedge clk);
		play = 1'b1;
		exp_index = 0;
		play_lines("full store", 2 * line_pkg::DEPTH, -1);
		stop_play("full store stop");
	endtask

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		logic [31:0] r;
		clk = 1'b0;
		rst_gen_mode = 1'b1;
		host_req = 1'b0;
		host_data = '0;
		play = 1'b0;
		restart = 1'b0;
		out_ack = 1'b0;
		lfsr = 16'd7;
		model_count = 0;
		exp_index = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (4) @(negedge clk);
		rst_gen_mode = 1'b0;
		@(negedge clk);
		check_status("reset", make_status(1'b1, 1'b0, 1'b0), status);
		if (host_ack || out_req) begin
			$display("reset: host_ack or out_req is high after reset");
			other_errors++;
		end
		for (int round = 0; round < ROUNDS; round++) begin
			rand_bits(4, r);
			play_round("generator", line_pkg::BUFF_LEN + 1 + int'(r));
			rand_bits(2, r);
			play_round("simple", 1 + int'(r) % line_pkg::BUFF_LEN);
			empty_store("empty store");
		end
		full_store();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
verilog/line_pkg.sv
verilog/line_bram.sv
verilog/line_loader.sv
verilog/line_player.sv
verilog/line_streamer.sv
verilog/line_player_top.sv
sim/tb_line_player.sv

//--- verilog/line_bram.sv
`timescale 1ns/1ps

module line_bram (
	input logic clk,
	input logic en,
	input logic we,
	input line_pkg::line_addr_t addr,
	input line_pkg::line_t din,
	output line_pkg::line_t dout
);

	line_pkg::line_t mem [line_pkg::DEPTH];

	// output register chain, one stage per cycle of latency.
	line_pkg::line_t rd_pipe [line_pkg::BRAM_DELAY];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
			end
			rd_pipe[0] <= mem[addr]; // read first.
		end
		for (int i = 1; i < line_pkg::BRAM_DELAY; i++) begin
			rd_pipe[i] <= rd_pipe[i-1]; // always enabled.
		end
	end

	assign dout = rd_pipe[line_pkg::BRAM_DELAY-1];

endmodule

//--- verilog/line_loader.sv
`timescale 1ns/1ps

module line_loader (
	input logic clk,
	input logic rst_gen_mode,
	input logic host_req,
	input line_pkg::line_t host_data,
	input logic write_rdy,
	output logic host_ack,
	output logic wr_en,
	output line_pkg::line_t wr_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_ACK
	} state_t;

	state_t state;
	line_pkg::line_t data_r;

	// ************************************************************
	// host handshake
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst_gen_mode) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// store full or busy playing holds the host off.
					if (host_req && write_rdy) begin
						state <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					state <= ST_ACK; // strobe lasts one cycle.
				end
				ST_ACK: begin
					if (!host_req) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// data is taken with the request.
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && host_req && write_rdy) begin
			data_r <= host_data;
		end
	end

	assign wr_en = state == ST_WRITE;
	assign wr_data = data_r;
	assign host_ack = state == ST_ACK; // drops one cycle after req.

endmodule

//--- verilog/line_pkg.sv
package line_pkg;

	// ************************************************************
	// sizes
	// ************************************************************

	localparam int LINE_WIDTH = 16;
	localparam int DEPTH = 32;
	localparam int ADDR_WIDTH = $clog2(DEPTH);
	localparam int BRAM_DELAY = 2; // cycles from address to data.
	localparam int BUFF_LEN = BRAM_DELAY + 1;

	// prefetch buffer pointers and occupancy.
	localparam int PTR_WIDTH = $clog2(BUFF_LEN);
	localparam int OCC_WIDTH = $clog2(BUFF_LEN + 1);

	// ************************************************************
	// types
	// ************************************************************

	typedef logic [LINE_WIDTH-1:0] line_t;
	typedef logic [ADDR_WIDTH-1:0] line_addr_t;
	typedef logic [ADDR_WIDTH:0] line_count_t; // holds DEPTH itself.

	typedef logic [PTR_WIDTH-1:0] buff_ptr_t;
	typedef logic [OCC_WIDTH-1:0] buff_occ_t;

	// a line on its way out with its position in the store.
	typedef struct packed {
		line_addr_t index;
		line_t data;
	} play_line_t;

	typedef struct packed {
		logic write_rdy; // write mode and store not full.
		logic playing; // lines available.
		logic error; // play on an empty store.
	} player_status_t;

endpackage

//--- verilog/line_player.sv
`timescale 1ns/1ps

module line_player (
	input logic clk,
	input logic rst_gen_mode,
	input logic play,
	input logic restart,
	input logic wr_en,
	input line_pkg::line_t wr_data,
	input logic next,
	output logic ram_en,
	output logic ram_we,
	output line_pkg::line_addr_t ram_addr,
	output line_pkg::line_t ram_din,
	input line_pkg::line_t ram_dout,
	output line_pkg::play_line_t cur_line,
	output line_pkg::player_status_t status
);

	typedef enum logic [2:0] {
		ST_WRITE,
		ST_PREP,
		ST_FILL,
		ST_GEN,
		ST_SIMPLE,
		ST_LEAVE,
		ST_ERROR
	} state_t;

	state_t state;
	line_pkg::line_count_t count;
	line_pkg::line_addr_t rd_addr; // address read while vld[0] is high.
	logic [line_pkg::BUFF_LEN-1:0] vld;
	line_pkg::line_t buff [line_pkg::BUFF_LEN];
	line_pkg::buff_ptr_t place_ptr;
	line_pkg::buff_ptr_t access_ptr;
	line_pkg::buff_occ_t occ;

	logic full;
	logic land;
	logic take;
	line_pkg::line_count_t rd_next;
	line_pkg::line_count_t gen_index;

	assign full = count == line_pkg::line_count_t'(line_pkg::DEPTH);
	assign land = vld[line_pkg::BUFF_LEN-1]; // ram_dout holds a requested line.
	assign take = next && status.playing;

	// ************************************************************
	// RAM port shared by write mode and playback
	// ************************************************************

	always_comb begin
		if (state == ST_WRITE) begin
			ram_en = wr_en;
			ram_we = wr_en && !full;
			ram_addr = count[line_pkg::ADDR_WIDTH-1:0]; // append at the end.
		end else begin
			ram_en = vld[0];
			ram_we = 1'b0;
			ram_addr = rd_addr;
		end
		ram_din = wr_data;
	end

	// ************************************************************
	// current line and status
	// ************************************************************

	// buffer plus reads in flight always hold BUFF_LEN lines, so the
	// front of the buffer sits BUFF_LEN behind the next read address.
	always_comb begin
		rd_next = line_pkg::line_count_t'(rd_addr) + line_pkg::line_count_t'(vld[0]);
		if (rd_next >= line_pkg::line_count_t'(line_pkg::BUFF_LEN)) begin
			gen_index = rd_next - line_pkg::line_count_t'(line_pkg::BUFF_LEN);
		end else begin
			gen_index = rd_next + count - line_pkg::line_count_t'(line_pkg::BUFF_LEN);
		end
	end

	always_comb begin
		if (state == ST_SIMPLE) begin
			cur_line.index = line_pkg::line_addr_t'(access_ptr); // whole store in buffer.
		end else begin
			cur_line.index = gen_index[line_pkg::ADDR_WIDTH-1:0];
		end
		cur_line.data = buff[access_ptr];
		status.write_rdy = (state == ST_WRITE) && !full;
		status.playing = ((state == ST_GEN) && (occ != '0)) || (state == ST_SIMPLE);
		status.error = state == ST_ERROR;
	end

	// ************************************************************
	// control
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst_gen_mode) begin
			state <= ST_WRITE;
			count <= '0;
			rd_addr <= '0;
			vld <= '0;
			place_ptr <= '0;
			access_ptr <= '0;
			occ <= '0;
		end else begin
			vld[line_pkg::BUFF_LEN-1:1] <= vld[line_pkg::BUFF_LEN-2:0];
			vld[0] <= 1'b0;
			if (land) begin
				place_ptr <= (place_ptr == line_pkg::buff_ptr_t'(line_pkg::BUFF_LEN - 1)) ?
					'0 : place_ptr + 1'b1;
			end

			case (state)
				ST_WRITE: begin
					if (wr_en && !full) begin
						count <= count + 1'b1;
					end
					if (play) begin
						state <= ST_PREP;
					end
				end

				ST_PREP: begin
					vld <= '0; // drop reads still in flight.
					rd_addr <= '0;
					place_ptr <= '0;
					access_ptr <= '0;
					occ <= '0;
					if (!play) begin
						state <= ST_LEAVE;
					end else if (!restart) begin
						if (count == '0) begin
							state <= ST_ERROR;
						end else begin
							vld[0] <= 1'b1;
							state <= ST_FILL;
						end
					end
				end

				ST_FILL: begin
					// read lines 0 .. BUFF_LEN-1 back to back.
					if (vld[0]) begin
						rd_addr <= rd_addr + 1'b1;
						vld[0] <= rd_addr != line_pkg::line_addr_t'(line_pkg::BUFF_LEN - 1);
					end
					if (land) begin
						occ <= occ + 1'b1;
					end
					if (!play) begin
						state <= ST_LEAVE;
					end else if (restart) begin
						state <= ST_PREP;
					end else if (occ == line_pkg::buff_occ_t'(line_pkg::BUFF_LEN)) begin
						state <= (count > line_pkg::line_count_t'(line_pkg::BUFF_LEN)) ?
							ST_GEN : ST_SIMPLE;
					end
				end

				ST_GEN: begin
					occ <= occ + line_pkg::buff_occ_t'(land) - line_pkg::buff_occ_t'(take);
					if (vld[0]) begin
						rd_addr <= (line_pkg::line_count_t'(rd_addr) == count - 1'b1) ?
							'0 : rd_addr + 1'b1; // loop over the store.
					end
					if (!play) begin
						state <= ST_LEAVE;
					end else if (restart) begin
						state <= ST_PREP;
					end else if (take) begin
						access_ptr <= (access_ptr == line_pkg::buff_ptr_t'(line_pkg::BUFF_LEN - 1)) ?
							'0 : access_ptr + 1'b1;
						vld[0] <= 1'b1; // refill the slot just freed.
					end
				end

				ST_SIMPLE: begin
					if (!play) begin
						state <= ST_LEAVE;
					end else if (restart) begin
						state <= ST_PREP;
					end else if (take) begin
						access_ptr <= (line_pkg::line_count_t'(access_ptr) == count - 1'b1) ?
							'0 : access_ptr + 1'b1;
					end
				end

				ST_LEAVE: begin
					count <= '0; // store is emptied.
					state <= ST_WRITE;
				end

				ST_ERROR: begin
					if (!play) begin
						state <= ST_LEAVE;
					end
				end

				default: begin
					state <= ST_WRITE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (land) begin
			buff[place_ptr] <= ram_dout;
		end
	end

endmodule

//--- verilog/line_player_top.sv
`timescale 1ns/1ps

module line_player_top (
	input logic clk,
	input logic rst_gen_mode,
	input logic host_req,
	input line_pkg::line_t host_data,
	input logic play,
	input logic restart,
	input logic out_ack,
	output logic host_ack,
	output logic out_req,
	output line_pkg::play_line_t out_line,
	output line_pkg::player_status_t status
);

	// loader to player.
	logic wr_en;
	line_pkg::line_t wr_data;

	// player to RAM.
	logic ram_en;
	logic ram_we;
	line_pkg::line_addr_t ram_addr;
	line_pkg::line_t ram_din;
	line_pkg::line_t ram_dout;

	// player to streamer.
	line_pkg::play_line_t cur_line;
	logic next;

	line_loader i_line_loader (
		.clk(clk),
		.rst_gen_mode(rst_gen_mode),
		.host_req(host_req),
		.host_data(host_data),
		.write_rdy(status.write_rdy),
		.host_ack(host_ack),
		.wr_en(wr_en),
		.wr_data(wr_data)
	);

	line_player i_line_player (
		.clk(clk),
		.rst_gen_mode(rst_gen_mode),
		.play(play),
		.restart(restart),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.next(next),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_din(ram_din),
		.ram_dout(ram_dout),
		.cur_line(cur_line),
		.status(status)
	);

	line_bram i_line_bram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.din(ram_din),
		.dout(ram_dout)
	);

	line_streamer i_line_streamer (
		.clk(clk),
		.rst_gen_mode(rst_gen_mode),
		.cur_line(cur_line),
		.playing(status.playing),
		.out_ack(out_ack),
		.next(next),
		.out_req(out_req),
		.out_line(out_line)
	);

endmodule

//--- verilog/line_streamer.sv
`timescale 1ns/1ps

module line_streamer (
	input logic clk,
	input logic rst_gen_mode,
	input line_pkg::play_line_t cur_line,
	input logic playing,
	input logic out_ack,
	output logic next,
	output logic out_req,
	output line_pkg::play_line_t out_line
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_NEXT,
		ST_REQ,
		ST_DROP
	} state_t;

	state_t state;

	// ************************************************************
	// output handshake
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst_gen_mode) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (playing) begin
						state <= ST_NEXT;
					end
				end
				ST_NEXT: begin
					// req is already up here.
					state <= out_ack ? ST_DROP : ST_REQ;
				end
				ST_REQ: begin
					if (out_ack) begin
						state <= ST_DROP;
					end
				end
				ST_DROP: begin
					if (!out_ack) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// held while the player moves on after next.
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && playing) begin
			out_line <= cur_line;
		end
	end

	assign next = state == ST_NEXT; // one cycle per line.
	assign out_req = (state == ST_NEXT) || (state == ST_REQ);

endmodule
